//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
TOP := tb_rv_hart
FILELIST := sim.f
BUILD_DIR := obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) dv/tb_rv_prog.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- common/rv_pkg.sv
package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_count = 32;
	localparam int ram_words = 256;

	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
	localparam logic [xlen-1:0] trap_pc = 32'h0000_0000; // no separate trap vector.

	// rv32i major opcodes, insn[6:0].
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;

	// what one instruction step sees.
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] insn;
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		logic [xlen-1:0] load_data;
	} step_in_t;

	// what one instruction step does.
	typedef struct packed {
		logic [xlen-1:0] next_pc;
		logic exception;
		logic rd_we;
		logic [4:0] rd_addr;
		logic [xlen-1:0] rd_wdata;
		logic [4:0] rs1_addr;
		logic [4:0] rs2_addr;
		logic load_en;
		logic [xlen-1:0] load_addr;
		logic store_en;
		logic [xlen-1:0] store_addr;
		logic [xlen-1:0] store_data;
	} step_out_t;

	// one record per retired instruction.
	typedef struct packed {
		logic valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] insn;
		logic trap;
		logic rd_we;
		logic [4:0] rd_addr;
		logic [xlen-1:0] rd_wdata;
		logic store_en;
		logic [xlen-1:0] store_addr;
		logic [xlen-1:0] store_data;
	} retire_t;

endpackage

//--- design/rv_data_ram.sv
`timescale 1ns/1ps

module rv_data_ram (
	input logic clk,
	input logic [rv_pkg::xlen-1:0] load_addr,
	output logic [rv_pkg::xlen-1:0] load_data,
	input logic store_en,
	input logic [rv_pkg::xlen-1:0] store_addr,
	input logic [rv_pkg::xlen-1:0] store_data
);
	import rv_pkg::*;

	logic [xlen-1:0] mem [ram_words];
	logic [$clog2(ram_words)-1:0] load_idx;
	logic [$clog2(ram_words)-1:0] store_idx;

	// word index, higher bits alias.
	assign load_idx = load_addr[$clog2(ram_words)+1:2];
	assign store_idx = store_addr[$clog2(ram_words)+1:2];

	assign load_data = mem[load_idx];

	always_ff @(posedge clk) begin
		if (store_en) begin
			mem[store_idx] <= store_data;
		end
	end

endmodule

//--- design/rv_hart.sv
`timescale 1ns/1ps

module rv_hart (
	input logic clk,
	input logic rst,
	output logic [rv_pkg::xlen-1:0] imem_addr,
	input logic [rv_pkg::xlen-1:0] imem_data,
	output rv_pkg::retire_t retire
);
	import rv_pkg::*;

	logic [xlen-1:0] pc;
	step_in_t step_in;
	step_out_t step_out;
	step_out_t model_out;
	logic model_valid;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] ram_data;
	logic rd_we;
	logic store_en;

	assign imem_addr = pc;

	// nothing commits in reset or on a trap.
	assign rd_we = step_out.rd_we && !step_out.exception && !rst;
	assign store_en = step_out.store_en && !step_out.exception && !rst;

	always_comb begin
		step_in.pc = pc;
		step_in.insn = imem_data;
		step_in.rs1_data = rs1_data;
		step_in.rs2_data = rs2_data;
		step_in.load_data = step_out.load_en ? ram_data : '0;
	end

	always_ff @(posedge clk) begin
		if (rst) pc <= reset_pc;
		else pc <= step_out.next_pc;
	end

	rv_spec_step i_rv_spec_step (.step_in(step_in), .step_out(step_out));

	rv_insn_model i_rv_insn_model (.step_in(step_in), .model_out(model_out),
		.model_valid(model_valid));

	rv_step_check i_rv_step_check (.clk(clk), .rst(rst), .step_in(step_in),
		.step_out(step_out), .model_out(model_out), .model_valid(model_valid));

	rv_regfile i_rv_regfile (.clk(clk), .rst(rst), .rs1_addr(step_out.rs1_addr),
		.rs2_addr(step_out.rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.we(rd_we), .rd_addr(step_out.rd_addr), .rd_wdata(step_out.rd_wdata));

	rv_data_ram i_rv_data_ram (.clk(clk), .load_addr(step_out.load_addr),
		.load_data(ram_data), .store_en(store_en), .store_addr(step_out.store_addr),
		.store_data(step_out.store_data));

	always_comb begin
		retire.valid = !rst;
		retire.pc = pc;
		retire.insn = imem_data;
		retire.trap = step_out.exception && !rst;
		retire.rd_we = rd_we;
		retire.rd_addr = step_out.rd_addr;
		retire.rd_wdata = step_out.rd_wdata;
		retire.store_en = store_en;
		retire.store_addr = step_out.store_addr;
		retire.store_data = step_out.store_data;
	end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input logic clk,
	input logic rst,
	input logic [4:0] rs1_addr,
	input logic [4:0] rs2_addr,
	output logic [rv_pkg::xlen-1:0] rs1_data,
	output logic [rv_pkg::xlen-1:0] rs2_data,
	input logic we,
	input logic [4:0] rd_addr,
	input logic [rv_pkg::xlen-1:0] rd_wdata
);
	import rv_pkg::*;

	logic [xlen-1:0] regs [1:reg_count-1]; // x0 has no storage.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd_addr != 5'd0) begin
			regs[rd_addr] <= rd_wdata;
		end
	end

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

	// the step unit is expected to drop x0 writes before they get here.
	a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
		we |-> rd_addr != 5'd0)
		else $error("register write aimed at x0");

endmodule

//--- dv/tb_rv_prog.svh
`ifndef TB_RV_PROG_SVH
`define TB_RV_PROG_SVH

localparam int imem_words = 64;
localparam int step_count = 29;

typedef struct packed {
	logic [31:0] pc;
	logic trap;
	logic rd_we;
	logic [4:0] rd_addr;
	logic [31:0] rd_wdata;
	logic store_en;
	logic [31:0] store_addr;
	logic [31:0] store_data;
} expect_t;

function automatic logic [31:0] prog_word(logic [31:0] addr);
	case (addr)
		32'h00: return 32'h06051863; // bne x10, x0, +0x70, re-entry guard.
		32'h04: return 32'h00500093; // addi x1, x0, 5.
		32'h08: return 32'hffd00113; // addi x2, x0, -3.
		32'h0c: return 32'h002081b3; // add x3, x1, x2.
		32'h10: return 32'h40208233; // sub x4, x1, x2.
		32'h14: return 32'h123452b7; // lui x5, 0x12345.
		32'h18: return 32'h00001317; // auipc x6, 0x1.
		32'h1c: return 32'h00708013; // addi x0, x1, 7.
		32'h20: return 32'h001003b3; // add x7, x0, x1.
		32'h24: return 32'h04000413; // addi x8, x0, 0x40.
		32'h28: return 32'h00542223; // sw x5, 4(x8).
		32'h2c: return 32'h00442483; // lw x9, 4(x8).
		32'h30: return 32'h00708463; // beq x1, x7, +8.
		32'h38: return 32'h00208463; // beq x1, x2, +8.
		32'h3c: return 32'h00209463; // bne x1, x2, +8.
		32'h44: return 32'h00709463; // bne x1, x7, +8.
		32'h48: return 32'h00c0066f; // jal x12, +12.
		32'h54: return 32'h06400693; // addi x13, x0, 0x64.
		32'h58: return 32'h00468767; // jalr x14, 4(x13).
		32'h68: return 32'h00100513; // addi x10, x0, 1.
		32'h6c: return 32'hffffffff; // illegal.
		32'h70: return 32'h00059663; // bne x11, x0, +12.
		32'h74: return 32'h00100593; // addi x11, x0, 1.
		32'h78: return 32'h00242783; // lw x15, 2(x8), misaligned.
		32'h7c: return 32'h00118813; // addi x16, x3, 1.
		32'h80: return 32'h0000006f; // jal x0, 0.
		// skipped words trap if ever fetched.
		default: return {addr[26:2], 7'h7f};
	endcase
endfunction

function automatic expect_t step_rec(logic [31:0] pc, logic trap, logic [4:0] rd,
	logic [31:0] wdata);
	expect_t e;
	e = '0;
	e.pc = pc;
	e.trap = trap;
	e.rd_we = (rd != 5'd0);
	e.rd_addr = rd;
	e.rd_wdata = wdata;
	return e;
endfunction

function automatic expect_t expected_step(int idx);
	expect_t e;
	case (idx)
		0: e = step_rec(32'h00, 1'b0, 5'd0, 32'h0);
		1: e = step_rec(32'h04, 1'b0, 5'd1, 32'h0000_0005);
		2: e = step_rec(32'h08, 1'b0, 5'd2, 32'hffff_fffd);
		3: e = step_rec(32'h0c, 1'b0, 5'd3, 32'h0000_0002);
		4: e = step_rec(32'h10, 1'b0, 5'd4, 32'h0000_0008);
		5: e = step_rec(32'h14, 1'b0, 5'd5, 32'h1234_5000);
		6: e = step_rec(32'h18, 1'b0, 5'd6, 32'h0000_1018);
		7: e = step_rec(32'h1c, 1'b0, 5'd0, 32'h0);
		8: e = step_rec(32'h20, 1'b0, 5'd7, 32'h0000_0005);
		9: e = step_rec(32'h24, 1'b0, 5'd8, 32'h0000_0040);
		10: begin
			e = step_rec(32'h28, 1'b0, 5'd0, 32'h0);
			e.store_en = 1'b1;
			e.store_addr = 32'h0000_0044;
			e.store_data = 32'h1234_5000;
		end
		11: e = step_rec(32'h2c, 1'b0, 5'd9, 32'h1234_5000);
		12: e = step_rec(32'h30, 1'b0, 5'd0, 32'h0);
		13: e = step_rec(32'h38, 1'b0, 5'd0, 32'h0);
		14: e = step_rec(32'h3c, 1'b0, 5'd0, 32'h0);
		15: e = step_rec(32'h44, 1'b0, 5'd0, 32'h0);
		16: e = step_rec(32'h48, 1'b0, 5'd12, 32'h0000_004c);
		17: e = step_rec(32'h54, 1'b0, 5'd13, 32'h0000_0064);
		18: e = step_rec(32'h58, 1'b0, 5'd14, 32'h0000_005c);
		19: e = step_rec(32'h68, 1'b0, 5'd10, 32'h0000_0001);
		20: e = step_rec(32'h6c, 1'b1, 5'd0, 32'h0);
		21: e = step_rec(32'h00, 1'b0, 5'd0, 32'h0); // guard taken.
		22: e = step_rec(32'h70, 1'b0, 5'd0, 32'h0);
		23: e = step_rec(32'h74, 1'b0, 5'd11, 32'h0000_0001);
		24: e = step_rec(32'h78, 1'b1, 5'd0, 32'h0);
		25: e = step_rec(32'h00, 1'b0, 5'd0, 32'h0);
		26: e = step_rec(32'h70, 1'b0, 5'd0, 32'h0);
		27: e = step_rec(32'h7c, 1'b0, 5'd16, 32'h0000_0003);
		28: e = step_rec(32'h80, 1'b0, 5'd0, 32'h0);
		default: e = '0;
	endcase
	return e;
endfunction

`endif

//--- dv/tb_rv_hart.sv
`timescale 1ns/1ps

module tb_rv_hart;
	import rv_pkg::*;

	`include "tb_rv_prog.svh"

	localparam int reset_cycles = 10;
	localparam int cycle_limit = step_count + reset_cycles + 20;

	logic clk;
	logic rst;
	logic [xlen-1:0] imem_addr;
	logic [xlen-1:0] imem_data;
	retire_t retire;
	logic [xlen-1:0] imem [imem_words];
	int step_idx;
	int cycle_count;
	logic checking;
	expect_t exp_now;
	logic [xlen-1:0] exp_insn;

	rv_hart i_rv_hart (.clk(clk), .rst(rst), .imem_addr(imem_addr),
		.imem_data(imem_data), .retire(retire));

	always #10 clk = ~clk;

	assign imem_data = imem[imem_addr[$clog2(imem_words)+1:2]]; // same-cycle fetch.
	assign checking = !rst && step_idx < step_count;
	assign exp_now = expected_step(step_idx);
	assign exp_insn = prog_word(exp_now.pc);

	always @(posedge clk) begin
		if (rst) begin
			step_idx <= 0;
		end else if (step_idx < step_count) begin
			step_idx <= step_idx + 1;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("*** FAILED ***");
			$fatal(1, "program did not finish within %0d cycles", cycle_limit);
		end
	end

	task automatic report_mismatch(string field, logic [31:0] got, logic [31:0] want);
		$display("ERR %s got %h expected %h", field, got, want);
		$display("*** FAILED ***");
		$fatal(1, "retire record mismatch");
	endtask

	a_valid: assert property (@(posedge clk) checking |-> retire.valid)
		else report_mismatch("retire.valid", $sampled(retire.valid), 32'h1);

	a_imem_addr: assert property (@(posedge clk) checking |-> imem_addr == exp_now.pc)
		else report_mismatch("imem_addr", $sampled(imem_addr), $sampled(exp_now.pc));

	a_pc: assert property (@(posedge clk) checking |-> retire.pc == exp_now.pc)
		else report_mismatch("retire.pc", $sampled(retire.pc), $sampled(exp_now.pc));

	a_insn: assert property (@(posedge clk) checking |-> retire.insn == exp_insn)
		else report_mismatch("retire.insn", $sampled(retire.insn), $sampled(exp_insn));

	a_trap: assert property (@(posedge clk) checking |-> retire.trap == exp_now.trap)
		else report_mismatch("retire.trap", $sampled(retire.trap), $sampled(exp_now.trap));

	a_rd_we: assert property (@(posedge clk) checking |-> retire.rd_we == exp_now.rd_we)
		else report_mismatch("retire.rd_we", $sampled(retire.rd_we),
			$sampled(exp_now.rd_we));

	a_rd_addr: assert property (@(posedge clk)
		checking && exp_now.rd_we |-> retire.rd_addr == exp_now.rd_addr)
		else report_mismatch("retire.rd_addr", $sampled(retire.rd_addr),
			$sampled(exp_now.rd_addr));

	a_rd_wdata: assert property (@(posedge clk)
		checking && exp_now.rd_we |-> retire.rd_wdata == exp_now.rd_wdata)
		else report_mismatch("retire.rd_wdata", $sampled(retire.rd_wdata),
			$sampled(exp_now.rd_wdata));

	a_store_en: assert property (@(posedge clk)
		checking |-> retire.store_en == exp_now.store_en)
		else report_mismatch("retire.store_en", $sampled(retire.store_en),
			$sampled(exp_now.store_en));

	a_store_addr: assert property (@(posedge clk)
		checking && exp_now.store_en |-> retire.store_addr == exp_now.store_addr)
		else report_mismatch("retire.store_addr", $sampled(retire.store_addr),
			$sampled(exp_now.store_addr));

	a_store_data: assert property (@(posedge clk)
		checking && exp_now.store_en |-> retire.store_data == exp_now.store_data)
		else report_mismatch("retire.store_data", $sampled(retire.store_data),
			$sampled(exp_now.store_data));

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cycle_count = 0;
		for (int i = 0; i < imem_words; i++) begin
			imem[i] = prog_word(32'(i * 4));
		end
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst = 1'b0;
		wait (step_idx == step_count); // last record checked at this edge.
		@(negedge clk);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- sim.f
+incdir+dv
common/rv_pkg.sv
spec/rv_spec_step.sv
spec/rv_insn_model.sv
spec/rv_step_check.sv
design/rv_regfile.sv
design/rv_data_ram.sv
design/rv_hart.sv
dv/tb_rv_hart.sv

//--- spec/rv_insn_model.sv
`timescale 1ns/1ps

module rv_insn_model (
	input rv_pkg::step_in_t step_in,
	output rv_pkg::step_out_t model_out,
	output logic model_valid
);
	import rv_pkg::*;

	logic [xlen-1:0] insn;
	logic [xlen-1:0] rs1;
	logic [xlen-1:0] rs2;
	logic [xlen-1:0] jalr_target;

	assign insn = step_in.insn;
	assign rs1 = step_in.rs1_data;
	assign rs2 = step_in.rs2_data;
	assign jalr_target = (rs1 + {{20{insn[31]}}, insn[31:20]}) & 32'hffff_fffe;

	// one branch per kept instruction, first match wins nothing since they are disjoint.
	always_comb begin
		model_out = '0;
		model_valid = 1'b0;
		model_out.rs1_addr = insn[19:15];
		model_out.rs2_addr = insn[24:20];
		model_out.rd_addr = insn[11:7];
		model_out.next_pc = step_in.pc + 32'd4;

		if (insn[6:0] == op_lui) begin
			model_valid = 1'b1;
			model_out.rd_we = 1'b1;
			model_out.rd_wdata = {insn[31:12], 12'h000};
		end
		if (insn[6:0] == op_auipc) begin
			model_valid = 1'b1;
			model_out.rd_we = 1'b1;
			model_out.rd_wdata = step_in.pc + {insn[31:12], 12'h000};
		end
		if (insn[6:0] == op_jal) begin
			model_valid = 1'b1;
			model_out.rd_we = 1'b1;
			model_out.rd_wdata = step_in.pc + 32'd4;
			model_out.next_pc = step_in.pc +
				{{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
		end
		if (insn[6:0] == op_jalr && insn[14:12] == 3'b000) begin
			model_valid = 1'b1;
			model_out.rd_we = 1'b1;
			model_out.rd_wdata = step_in.pc + 32'd4;
			model_out.next_pc = jalr_target;
		end
		if (insn[6:0] == op_branch && insn[14:12] == 3'b000) begin // beq.
			model_valid = 1'b1;
			if (rs1 == rs2)
				model_out.next_pc = step_in.pc +
					{{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
		end
		if (insn[6:0] == op_branch && insn[14:12] == 3'b001) begin // bne.
			model_valid = 1'b1;
			if (rs1 != rs2)
				model_out.next_pc = step_in.pc +
					{{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
		end
		if (insn[6:0] == op_imm && insn[14:12] == 3'b000) begin // addi.
			model_valid = 1'b1;
			model_out.rd_we = 1'b1;
			model_out.rd_wdata = rs1 + {{20{insn[31]}}, insn[31:20]};
		end
		if (insn[6:0] == op_reg && insn[14:12] == 3'b000 && insn[31:25] == 7'h00) begin
			model_valid = 1'b1;
			model_out.rd_we = 1'b1;
			model_out.rd_wdata = rs1 + rs2;
		end
		if (insn[6:0] == op_reg && insn[14:12] == 3'b000 && insn[31:25] == 7'h20) begin
			model_valid = 1'b1;
			model_out.rd_we = 1'b1;
			model_out.rd_wdata = rs1 - rs2;
		end
		if (insn[6:0] == op_load && insn[14:12] == 3'b010) begin // lw.
			model_valid = 1'b1;
			model_out.load_en = 1'b1;
			model_out.load_addr = rs1 + {{20{insn[31]}}, insn[31:20]};
			model_out.rd_we = 1'b1;
			model_out.rd_wdata = step_in.load_data;
		end
		if (insn[6:0] == op_store && insn[14:12] == 3'b010) begin // sw.
			model_valid = 1'b1;
			model_out.store_en = 1'b1;
			model_out.store_addr = rs1 + {{20{insn[31]}}, insn[31:25], insn[11:7]};
			model_out.store_data = rs2;
		end

		if (model_out.rd_addr == 5'd0) model_out.rd_we = 1'b0;
		model_out.exception = !model_valid || model_out.next_pc[1:0] != 2'b00 ||
			(model_out.load_en && model_out.load_addr[1:0] != 2'b00) ||
			(model_out.store_en && model_out.store_addr[1:0] != 2'b00);
		if (model_out.exception) begin
			model_out.next_pc = trap_pc;
			model_out.rd_we = 1'b0;
			model_out.load_en = 1'b0;
			model_out.store_en = 1'b0;
		end
	end

endmodule

//--- spec/rv_spec_step.sv
`timescale 1ns/1ps

module rv_spec_step (
	input rv_pkg::step_in_t step_in,
	output rv_pkg::step_out_t step_out
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [4:0] rd;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] jalr_sum;
	logic legal;
	logic misaligned;
	step_out_t res;

	assign opcode = step_in.insn[6:0];
	assign rd = step_in.insn[11:7];
	assign funct3 = step_in.insn[14:12];
	assign funct7 = step_in.insn[31:25];

	assign imm_i = {{20{step_in.insn[31]}}, step_in.insn[31:20]};
	assign imm_s = {{20{step_in.insn[31]}}, step_in.insn[31:25], step_in.insn[11:7]};
	assign imm_b = {{19{step_in.insn[31]}}, step_in.insn[31], step_in.insn[7],
		step_in.insn[30:25], step_in.insn[11:8], 1'b0};
	assign imm_u = {step_in.insn[31:12], 12'h000};
	assign imm_j = {{11{step_in.insn[31]}}, step_in.insn[31], step_in.insn[19:12],
		step_in.insn[20], step_in.insn[30:21], 1'b0};

	assign pc_plus4 = step_in.pc + 32'd4;
	assign jalr_sum = step_in.rs1_data + imm_i;

	always_comb begin
		res = '0;
		res.rs1_addr = step_in.insn[19:15];
		res.rs2_addr = step_in.insn[24:20];
		res.rd_addr = rd;
		res.next_pc = pc_plus4;
		legal = 1'b1;
		case (opcode)
			op_lui: begin
				res.rd_we = 1'b1;
				res.rd_wdata = imm_u;
			end
			op_auipc: begin
				res.rd_we = 1'b1;
				res.rd_wdata = step_in.pc + imm_u;
			end
			op_jal: begin
				res.rd_we = 1'b1;
				res.rd_wdata = pc_plus4;
				res.next_pc = step_in.pc + imm_j;
			end
			op_jalr: begin
				legal = (funct3 == 3'b000);
				res.rd_we = 1'b1;
				res.rd_wdata = pc_plus4;
				res.next_pc = {jalr_sum[xlen-1:1], 1'b0}; // bit 0 dropped.
			end
			op_branch: begin
				case (funct3)
					3'b000: if (step_in.rs1_data == step_in.rs2_data)
						res.next_pc = step_in.pc + imm_b;
					3'b001: if (step_in.rs1_data != step_in.rs2_data)
						res.next_pc = step_in.pc + imm_b;
					default: legal = 1'b0;
				endcase
			end
			op_load: begin
				legal = (funct3 == 3'b010); // lw only.
				res.load_en = 1'b1;
				res.load_addr = step_in.rs1_data + imm_i;
				res.rd_we = 1'b1;
				res.rd_wdata = step_in.load_data;
			end
			op_store: begin
				legal = (funct3 == 3'b010); // sw only.
				res.store_en = 1'b1;
				res.store_addr = step_in.rs1_data + imm_s;
				res.store_data = step_in.rs2_data;
			end
			op_imm: begin
				legal = (funct3 == 3'b000); // addi only.
				res.rd_we = 1'b1;
				res.rd_wdata = step_in.rs1_data + imm_i;
			end
			op_reg: begin
				res.rd_we = 1'b1;
				if (funct3 == 3'b000 && funct7 == 7'b0000000)
					res.rd_wdata = step_in.rs1_data + step_in.rs2_data;
				else if (funct3 == 3'b000 && funct7 == 7'b0100000)
					res.rd_wdata = step_in.rs1_data - step_in.rs2_data;
				else
					legal = 1'b0;
			end
			default: legal = 1'b0;
		endcase

		misaligned = (res.next_pc[1:0] != 2'b00) ||
			(res.load_en && res.load_addr[1:0] != 2'b00) ||
			(res.store_en && res.store_addr[1:0] != 2'b00);
		if (rd == 5'd0) res.rd_we = 1'b0; // x0 is never written.
		if (!legal || misaligned) begin
			res.exception = 1'b1;
			res.next_pc = trap_pc;
			res.rd_we = 1'b0;
			res.load_en = 1'b0;
			res.store_en = 1'b0;
		end
	end

	assign step_out = res;

endmodule

//--- spec/rv_step_check.sv
`timescale 1ns/1ps

module rv_step_check (
	input logic clk,
	input logic rst,
	input rv_pkg::step_in_t step_in,
	input rv_pkg::step_out_t step_out,
	input rv_pkg::step_out_t model_out,
	input logic model_valid
);
	import rv_pkg::*;

	logic model_trap;

	assign model_trap = !model_valid || model_out.exception;

	// a trap commits nothing and restarts at the trap pc.
	a_trap: assert property (@(posedge clk) disable iff (rst)
		model_trap |-> step_out.exception && step_out.next_pc == trap_pc &&
			!step_out.rd_we && !step_out.load_en && !step_out.store_en)
		else $error("step trap mismatch at pc %h insn %h", step_in.pc, step_in.insn);

	a_next_pc: assert property (@(posedge clk) disable iff (rst)
		!model_trap |-> !step_out.exception && step_out.next_pc == model_out.next_pc)
		else $error("next pc %h, model %h", step_out.next_pc, model_out.next_pc);

	a_rd: assert property (@(posedge clk) disable iff (rst)
		!model_trap |-> step_out.rd_we == model_out.rd_we &&
			(!step_out.rd_we || (step_out.rd_addr == model_out.rd_addr &&
			step_out.rd_wdata == model_out.rd_wdata)))
		else $error("rd write x%0d=%h, model x%0d=%h", step_out.rd_addr,
			step_out.rd_wdata, model_out.rd_addr, model_out.rd_wdata);

	a_mem_en: assert property (@(posedge clk) disable iff (rst)
		!model_trap |-> step_out.load_en == model_out.load_en &&
			step_out.store_en == model_out.store_en)
		else $error("memory strobes differ from model at pc %h", step_in.pc);

	a_load: assert property (@(posedge clk) disable iff (rst)
		step_out.load_en |-> model_out.load_en && step_out.load_addr == model_out.load_addr)
		else $error("load addr %h, model %h", step_out.load_addr, model_out.load_addr);

	// address and data both, not only the strobe.
	a_store: assert property (@(posedge clk) disable iff (rst)
		step_out.store_en |-> model_out.store_en &&
			step_out.store_addr == model_out.store_addr &&
			step_out.store_data == model_out.store_data)
		else $error("store %h<-%h, model %h<-%h", step_out.store_addr,
			step_out.store_data, model_out.store_addr, model_out.store_data);

	always @(posedge clk) begin
		if (!rst) begin
			assert (step_in.pc[1:0] == 2'b00)
				else $error("pc %h not word aligned", step_in.pc);
		end
	end

endmodule
